//--- hw/wb_cfg_pkg.sv
package wb_cfg_pkg;

    // datapath width
    localparam int XLEN = 64;

    // physical register file, tag 0 is never written
    localparam int PHYS_REGS = 128;

    // reorder buffer entries
    localparam int ROB_DEPTH = 64;

    // completion bus slots per cycle
    localparam int WB_SLOTS = 2;

    // functional-unit producers
    localparam int NUM_FU = 4;

    // fu producers plus the load port, which sits at index NUM_FU
    localparam int NUM_PROD = NUM_FU + 1;

    // per-producer queue depth = credits handed out after reset
    localparam int RQ_DEPTH = 4;

endpackage

//--- hw/wb_types_pkg.sv
package wb_types_pkg;

    typedef logic [wb_cfg_pkg::XLEN-1:0]               data_t;
    typedef logic [$clog2(wb_cfg_pkg::PHYS_REGS)-1:0]  prf_tag_t;  // 7 bits
    typedef logic [$clog2(wb_cfg_pkg::ROB_DEPTH)-1:0]  rob_idx_t;  // 6 bits
    typedef logic [2:0]                                funct3_t;
    typedef logic [$clog2(wb_cfg_pkg::NUM_PROD)-1:0]   prod_sel_t; // 3 bits

    // encoding matches funct3[1:0] of the load opcodes
    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        prf_tag_t  dest_prf;
        data_t     value;
        data_t     link_value; // pc + 4 for jal/jalr
        logic      is_jtype;
        logic      exception;
        logic      mispred;
    } fu_result_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        prf_tag_t  dest_prf;
        data_t     data;       // raw, unextended
        mem_size_e size;
        funct3_t   funct3;
    } load_result_t;

    typedef struct packed {
        logic     en;
        prf_tag_t addr;
        data_t    data;
    } prf_wr_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        data_t    value;
        logic     exception;
        logic     mispred;
    } rob_wb_t;

    typedef struct packed {
        logic     valid;
        prf_tag_t phys_tag;
        data_t    value;
    } cdb_entry_t;

endpackage

//--- hw/load_align.sv
`timescale 1ns/1ns

module load_align (
    input  wb_types_pkg::load_result_t load_i,
    output wb_types_pkg::fu_result_t   result_o
);

    logic is_unsigned;

    assign is_unsigned = load_i.funct3[2]; // lbu / lhu / lwu

    always_comb begin
        result_o          = '0; // no jump, exception or mispredict from the lsq
        result_o.valid    = load_i.valid;
        result_o.rob_idx  = load_i.rob_idx;
        result_o.dest_prf = load_i.dest_prf;
        unique case (load_i.size)
            wb_types_pkg::BYTE: begin
                result_o.value = is_unsigned ?
                    {{(wb_cfg_pkg::XLEN-8){1'b0}}, load_i.data[7:0]} :
                    {{(wb_cfg_pkg::XLEN-8){load_i.data[7]}}, load_i.data[7:0]};
            end
            wb_types_pkg::HALF: begin
                result_o.value = is_unsigned ?
                    {{(wb_cfg_pkg::XLEN-16){1'b0}}, load_i.data[15:0]} :
                    {{(wb_cfg_pkg::XLEN-16){load_i.data[15]}}, load_i.data[15:0]};
            end
            wb_types_pkg::WORD: begin
                result_o.value = is_unsigned ?
                    {{(wb_cfg_pkg::XLEN-32){1'b0}}, load_i.data[31:0]} :
                    {{(wb_cfg_pkg::XLEN-32){load_i.data[31]}}, load_i.data[31:0]};
            end
            wb_types_pkg::DOUBLE: begin
                result_o.value = load_i.data;
            end
        endcase
    end

    // lsq must hand over a size that agrees with the decoded funct3
    always_comb begin
        if (load_i.valid) begin
            assert (load_i.funct3[1:0] == load_i.size && load_i.funct3 != 3'b111)
            else $error("load_align: funct3 %b inconsistent with size %0d",
                        load_i.funct3, load_i.size);
        end
    end

endmodule

//--- hw/result_queue.sv
`timescale 1ns/1ns

module result_queue (
    input  logic                     clock,
    input  logic                     reset_i,
    input  wb_types_pkg::fu_result_t push_i,
    input  logic                     pop_i,
    output wb_types_pkg::fu_result_t head_o,
    output logic                     not_empty_o,
    output logic                     credit_o
);

    typedef logic [$clog2(wb_cfg_pkg::RQ_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(wb_cfg_pkg::RQ_DEPTH+1)-1:0] cnt_t;

    wb_types_pkg::fu_result_t mem [wb_cfg_pkg::RQ_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(wb_cfg_pkg::RQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // payload storage
    always_ff @(posedge clock) begin
        if (push_i.valid) begin
            mem[wr_ptr] <= push_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i.valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i.valid, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or push and pop together
            endcase
            credit_o <= pop_i; // one credit back per drained entry
        end
    end

    assign not_empty_o = (count != '0);

    always_comb begin
        head_o       = mem[rd_ptr];
        head_o.valid = not_empty_o;
    end

    // credits are only returned a cycle after the pop, so a full queue means
    // the producer has none left
    a_no_push_full: assert property (@(posedge clock) disable iff (reset_i)
        push_i.valid |-> (count != cnt_t'(wb_cfg_pkg::RQ_DEPTH)))
        else $error("result_queue: push while full");

    // arbiter must only grant non-empty queues
    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset_i)
        pop_i |-> not_empty_o)
        else $error("result_queue: pop while empty");

endmodule

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic                                             clock,
    input  logic                                             reset_i,
    input  logic [wb_cfg_pkg::NUM_PROD-1:0]                  req_i,
    output logic [wb_cfg_pkg::NUM_PROD-1:0]                  grant_o,
    output logic [wb_cfg_pkg::WB_SLOTS-1:0]                  slot_valid_o,
    output wb_types_pkg::prod_sel_t [wb_cfg_pkg::WB_SLOTS-1:0] slot_sel_o
);

    wb_types_pkg::prod_sel_t ptr_q;  // highest priority producer
    wb_types_pkg::prod_sel_t ptr_d;

    // scan from ptr_q and hand out slots in order
    always_comb begin
        int idx;
        int n;
        int last;
        grant_o      = '0;
        slot_valid_o = '0;
        slot_sel_o   = '0;
        n            = 0;
        last         = int'(ptr_q);
        for (int k = 0; k < wb_cfg_pkg::NUM_PROD; k++) begin
            idx = (int'(ptr_q) + k) % wb_cfg_pkg::NUM_PROD;
            if (req_i[idx] && n < wb_cfg_pkg::WB_SLOTS) begin
                grant_o[idx]     = 1'b1;
                slot_valid_o[n]  = 1'b1;
                slot_sel_o[n]    = wb_types_pkg::prod_sel_t'(idx);
                last             = idx;
                n++;
            end
        end
        ptr_d = wb_types_pkg::prod_sel_t'((last + 1) % wb_cfg_pkg::NUM_PROD);
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (|grant_o) begin
            ptr_q <= ptr_d; // one past the last winner
        end
    end

    a_grant_has_req: assert property (@(posedge clock) disable iff (reset_i)
        (grant_o & ~req_i) == '0)
        else $error("cdb_arbiter: grant without request %b / %b", grant_o, req_i);

    for (genvar a = 0; a < wb_cfg_pkg::WB_SLOTS; a++) begin : g_uniq_a
        for (genvar b = a + 1; b < wb_cfg_pkg::WB_SLOTS; b++) begin : g_uniq_b
            a_slot_unique: assert property (@(posedge clock) disable iff (reset_i)
                (slot_valid_o[a] && slot_valid_o[b]) |-> (slot_sel_o[a] != slot_sel_o[b]))
                else $error("cdb_arbiter: producer %0d granted on two slots", slot_sel_o[a]);
        end
    end

endmodule

//--- hw/complete_stage.sv
`timescale 1ns/1ns

module complete_stage (
    input  logic                                                clock,
    input  logic                                                reset_i,
    input  wb_types_pkg::fu_result_t  [wb_cfg_pkg::NUM_PROD-1:0] heads_i,
    input  logic [wb_cfg_pkg::WB_SLOTS-1:0]                     slot_valid_i,
    input  wb_types_pkg::prod_sel_t   [wb_cfg_pkg::WB_SLOTS-1:0] slot_sel_i,
    output wb_types_pkg::prf_wr_t     [wb_cfg_pkg::WB_SLOTS-1:0] prf_wr_o,
    output wb_types_pkg::rob_wb_t     [wb_cfg_pkg::WB_SLOTS-1:0] rob_wb_o,
    output wb_types_pkg::cdb_entry_t  [wb_cfg_pkg::WB_SLOTS-1:0] cdb_o
);

    wb_types_pkg::prf_wr_t    [wb_cfg_pkg::WB_SLOTS-1:0] prf_wr_d;
    wb_types_pkg::rob_wb_t    [wb_cfg_pkg::WB_SLOTS-1:0] rob_wb_d;
    wb_types_pkg::cdb_entry_t [wb_cfg_pkg::WB_SLOTS-1:0] cdb_d;

    always_comb begin
        wb_types_pkg::fu_result_t res;
        wb_types_pkg::data_t      wb_val;
        logic                     wr_ok;
        prf_wr_d = '0;
        rob_wb_d = '0;
        cdb_d    = '0;
        for (int s = 0; s < wb_cfg_pkg::WB_SLOTS; s++) begin
            res    = heads_i[slot_sel_i[s]];
            wb_val = res.is_jtype ? res.link_value : res.value; // jal/jalr write pc+4
            // excepting results and x0 renames never reach the prf or the bus
            wr_ok  = slot_valid_i[s] && !res.exception && (res.dest_prf != '0);

            if (slot_valid_i[s]) begin
                rob_wb_d[s].valid     = 1'b1;
                rob_wb_d[s].rob_idx   = res.rob_idx;
                rob_wb_d[s].value     = wb_val;
                rob_wb_d[s].exception = res.exception;
                rob_wb_d[s].mispred   = res.mispred;
            end

            if (wr_ok) begin
                prf_wr_d[s].en       = 1'b1;
                prf_wr_d[s].addr     = res.dest_prf;
                prf_wr_d[s].data     = wb_val;
                cdb_d[s].valid       = 1'b1;
                cdb_d[s].phys_tag    = res.dest_prf;
                cdb_d[s].value       = wb_val;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            prf_wr_o <= '0;
            rob_wb_o <= '0;
            cdb_o    <= '0;
        end else begin
            prf_wr_o <= prf_wr_d;
            rob_wb_o <= rob_wb_d;
            cdb_o    <= cdb_d;
        end
    end

    // rename hands out each physical tag once, so same-cycle writes never collide
    for (genvar a = 0; a < wb_cfg_pkg::WB_SLOTS; a++) begin : g_tag_a
        for (genvar b = a + 1; b < wb_cfg_pkg::WB_SLOTS; b++) begin : g_tag_b
            a_prf_tag_unique: assert property (@(posedge clock) disable iff (reset_i)
                (prf_wr_o[a].en && prf_wr_o[b].en) |-> (prf_wr_o[a].addr != prf_wr_o[b].addr))
                else $error("complete_stage: two prf writes to tag %0d", prf_wr_o[a].addr);
        end
    end

endmodule

//--- hw/wb_top.sv
`timescale 1ns/1ns

module wb_top (
    input  logic                                               clock,
    input  logic                                               reset_i,
    input  wb_types_pkg::fu_result_t [wb_cfg_pkg::NUM_FU-1:0]   fu_res_i,
    input  wb_types_pkg::load_result_t                         load_i,
    output logic [wb_cfg_pkg::NUM_PROD-1:0]                    credit_o,
    output wb_types_pkg::prf_wr_t    [wb_cfg_pkg::WB_SLOTS-1:0] prf_wr_o,
    output wb_types_pkg::rob_wb_t    [wb_cfg_pkg::WB_SLOTS-1:0] rob_wb_o,
    output wb_types_pkg::cdb_entry_t [wb_cfg_pkg::WB_SLOTS-1:0] cdb_o
);

    wb_types_pkg::fu_result_t                            load_res; // extended load
    wb_types_pkg::fu_result_t [wb_cfg_pkg::NUM_PROD-1:0] heads;
    logic [wb_cfg_pkg::NUM_PROD-1:0]                     not_empty;
    logic [wb_cfg_pkg::NUM_PROD-1:0]                     grant;
    logic [wb_cfg_pkg::WB_SLOTS-1:0]                     slot_valid;
    wb_types_pkg::prod_sel_t  [wb_cfg_pkg::WB_SLOTS-1:0] slot_sel;

    load_align u_load_align (
        .load_i   (load_i),
        .result_o (load_res)
    );

    for (genvar i = 0; i < wb_cfg_pkg::NUM_FU; i++) begin : g_fu_q
        result_queue u_fu_q (
            .clock       (clock),
            .reset_i     (reset_i),
            .push_i      (fu_res_i[i]),
            .pop_i       (grant[i]),
            .head_o      (heads[i]),
            .not_empty_o (not_empty[i]),
            .credit_o    (credit_o[i])
        );
    end

    // load port takes the last producer index
    result_queue u_ld_q (
        .clock       (clock),
        .reset_i     (reset_i),
        .push_i      (load_res),
        .pop_i       (grant[wb_cfg_pkg::NUM_FU]),
        .head_o      (heads[wb_cfg_pkg::NUM_FU]),
        .not_empty_o (not_empty[wb_cfg_pkg::NUM_FU]),
        .credit_o    (credit_o[wb_cfg_pkg::NUM_FU])
    );

    cdb_arbiter u_arb (
        .clock        (clock),
        .reset_i      (reset_i),
        .req_i        (not_empty),
        .grant_o      (grant),
        .slot_valid_o (slot_valid),
        .slot_sel_o   (slot_sel)
    );

    complete_stage u_complete (
        .clock        (clock),
        .reset_i      (reset_i),
        .heads_i      (heads),
        .slot_valid_i (slot_valid),
        .slot_sel_i   (slot_sel),
        .prf_wr_o     (prf_wr_o),
        .rob_wb_o     (rob_wb_o),
        .cdb_o        (cdb_o)
    );

endmodule

//--- dv/tb_wb_top.sv
`timescale 1ns/1ns

module tb_wb_top;

    localparam int STIM_CYCLES = 600;
    localparam int DRAIN_LIMIT = 200;

    // what one ROB index must complete with
    typedef struct packed {
        wb_types_pkg::data_t    value;
        wb_types_pkg::prf_tag_t tag;
        logic                   exception;
        logic                   mispred;
    } expect_t;

    logic clock;
    logic reset_i;
    wb_types_pkg::fu_result_t   [wb_cfg_pkg::NUM_FU-1:0]   fu_res;
    wb_types_pkg::load_result_t                            load_res;
    logic [wb_cfg_pkg::NUM_PROD-1:0]                       credit;
    wb_types_pkg::prf_wr_t      [wb_cfg_pkg::WB_SLOTS-1:0] prf_wr;
    wb_types_pkg::rob_wb_t      [wb_cfg_pkg::WB_SLOTS-1:0] rob_wb;
    wb_types_pkg::cdb_entry_t   [wb_cfg_pkg::WB_SLOTS-1:0] cdb;

    integer  seed = 32'hca982a6e;
    expect_t exp_q      [wb_cfg_pkg::ROB_DEPTH];
    int      issue_cnt  [wb_cfg_pkg::ROB_DEPTH];
    int      retire_cnt [wb_cfg_pkg::ROB_DEPTH];
    int      credits    [wb_cfg_pkg::NUM_PROD];
    int      wait_cnt   [wb_cfg_pkg::NUM_PROD];   // cycles outstanding without a credit back
    logic [wb_cfg_pkg::ROB_DEPTH-1:0] pending;
    logic    rst_q = 1'b0;
    logic    out_busy;

    wb_top u_dut (
        .clock    (clock),
        .reset_i  (reset_i),
        .fu_res_i (fu_res),
        .load_i   (load_res),
        .credit_o (credit),
        .prf_wr_o (prf_wr),
        .rob_wb_o (rob_wb),
        .cdb_o    (cdb)
    );

    always #4 clock = ~clock;

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input wb_types_pkg::data_t got,
                                   input wb_types_pkg::data_t want);
        end_with_failure($sformatf("[FAIL] t=%0t %s got 0x%h expected 0x%h",
                                   $time, name, got, want));
    endtask

    // keep the low bytes, then fill the rest with zeros or the top kept bit
    function automatic wb_types_pkg::data_t extend_load(input wb_types_pkg::data_t raw,
                                                        input wb_types_pkg::mem_size_e size,
                                                        input wb_types_pkg::funct3_t f3);
        int                  bits;
        wb_types_pkg::data_t mask;
        if (size == wb_types_pkg::DOUBLE) begin
            return raw;
        end
        bits = 8 << int'(size);
        mask = (wb_types_pkg::data_t'(1) << bits) - 1;
        if (!f3[2] && raw[bits-1]) begin
            return raw | ~mask;
        end
        return raw & mask;
    endfunction

    function automatic int pick_free_rob(input int start);
        int idx;
        for (int k = 0; k < wb_cfg_pkg::ROB_DEPTH; k++) begin
            idx = (start + k) % wb_cfg_pkg::ROB_DEPTH;
            if (issue_cnt[idx] == retire_cnt[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic bit all_returned();
        for (int p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin
            if (credits[p] != wb_cfg_pkg::RQ_DEPTH) begin
                return 1'b0;
            end
        end
        return (pending == '0);
    endfunction

    task automatic collect_credits();
        for (int p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin
            if (credit[p]) begin
                credits[p]++;
            end
        end
    endtask

    task automatic drive_cycle(input bit always_send);
        wb_types_pkg::fu_result_t [wb_cfg_pkg::NUM_FU-1:0] fu_next;
        wb_types_pkg::load_result_t ld_next;
        logic [31:0]                r;
        int                         idx;
        expect_t                    e;
        fu_next = '0;
        ld_next = '0;
        for (int p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin
            r   = $random(seed);
            idx = pick_free_rob(int'(r[5:0]));
            if (credits[p] > 0 && idx >= 0 && (always_send || r[6])) begin
                credits[p]--;
                issue_cnt[idx]++;
                r     = $random(seed);
                e.tag = (r[2:0] == 3'd0) ? '0 : wb_types_pkg::prf_tag_t'(idx + 1); // some x0
                if (p < wb_cfg_pkg::NUM_FU) begin
                    fu_next[p].valid      = 1'b1;
                    fu_next[p].rob_idx    = wb_types_pkg::rob_idx_t'(idx);
                    fu_next[p].dest_prf   = e.tag;
                    fu_next[p].value      = {$random(seed), $random(seed)};
                    fu_next[p].link_value = {$random(seed), $random(seed)};
                    fu_next[p].is_jtype   = (r[4:3] == 2'd0);
                    fu_next[p].exception  = (r[7:5] == 3'd0);
                    fu_next[p].mispred    = (r[10:8] == 3'd0);
                    e.value     = fu_next[p].is_jtype ? fu_next[p].link_value : fu_next[p].value;
                    e.exception = fu_next[p].exception;
                    e.mispred   = fu_next[p].mispred;
                end else begin
                    ld_next.valid    = 1'b1;
                    ld_next.rob_idx  = wb_types_pkg::rob_idx_t'(idx);
                    ld_next.dest_prf = e.tag;
                    ld_next.data     = {$random(seed), $random(seed)};
                    ld_next.size     = wb_types_pkg::mem_size_e'(r[12:11]);
                    ld_next.funct3   = {r[13] && r[12:11] != 2'd3, r[12:11]}; // no ldu
                    e.value     = extend_load(ld_next.data, ld_next.size, ld_next.funct3);
                    e.exception = 1'b0;
                    e.mispred   = 1'b0;
                end
                exp_q[idx] = e;
            end
        end
        fu_res   = fu_next;
        load_res = ld_next;
    endtask

    always_comb begin
        for (int i = 0; i < wb_cfg_pkg::ROB_DEPTH; i++) begin
            pending[i] = (issue_cnt[i] != retire_cnt[i]);
        end
    end

    always_comb begin
        out_busy = |credit;
        for (int s = 0; s < wb_cfg_pkg::WB_SLOTS; s++) begin
            out_busy = out_busy | prf_wr[s].en | rob_wb[s].valid | cdb[s].valid;
        end
    end

    always @(posedge clock) begin : retire_track
        if (!reset_i) begin
            for (int s = 0; s < wb_cfg_pkg::WB_SLOTS; s++) begin
                if (rob_wb[s].valid) begin
                    retire_cnt[rob_wb[s].rob_idx] <= retire_cnt[rob_wb[s].rob_idx] + 1;
                end
            end
        end
    end

    always @(posedge clock) begin
        rst_q <= reset_i;
        for (int p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin
            if (reset_i || credit[p] || credits[p] == wb_cfg_pkg::RQ_DEPTH) begin
                wait_cnt[p] <= 0;
            end else begin
                wait_cnt[p] <= wait_cnt[p] + 1;
            end
        end
    end

    a_idle_reset: assert property (@(posedge clock) rst_q |-> !out_busy)
        else end_with_failure("an output valid or credit was high during or right after reset");

    for (genvar s = 0; s < wb_cfg_pkg::WB_SLOTS; s++) begin : g_slot
        expect_t want;
        logic    want_wr;

        assign want    = exp_q[rob_wb[s].rob_idx];
        assign want_wr = !want.exception && (want.tag != '0);

        a_rob_once: assert property (@(posedge clock) disable iff (reset_i)
            rob_wb[s].valid |-> pending[rob_wb[s].rob_idx])
            else end_with_failure($sformatf("rob_wb_o[%0d] completed ROB index %0d, not outstanding",
                                            s, $sampled(rob_wb[s].rob_idx)));
        a_rob_value: assert property (@(posedge clock) disable iff (reset_i)
            rob_wb[s].valid |-> rob_wb[s].value == want.value)
            else report_mismatch($sformatf("rob_wb_o[%0d].value", s),
                                 $sampled(rob_wb[s].value), $sampled(want.value));
        a_rob_flags: assert property (@(posedge clock) disable iff (reset_i)
            rob_wb[s].valid |->
                {rob_wb[s].exception, rob_wb[s].mispred} == {want.exception, want.mispred})
            else report_mismatch($sformatf("rob_wb_o[%0d].{exception,mispred}", s),
                                 $sampled({rob_wb[s].exception, rob_wb[s].mispred}),
                                 $sampled({want.exception, want.mispred}));
        a_prf_en: assert property (@(posedge clock) disable iff (reset_i)
            prf_wr[s].en == (rob_wb[s].valid && want_wr))
            else report_mismatch($sformatf("prf_wr_o[%0d].en", s), $sampled(prf_wr[s].en),
                                 $sampled(rob_wb[s].valid && want_wr));
        a_prf_addr: assert property (@(posedge clock) disable iff (reset_i)
            prf_wr[s].en |-> prf_wr[s].addr == want.tag)
            else report_mismatch($sformatf("prf_wr_o[%0d].addr", s),
                                 $sampled(prf_wr[s].addr), $sampled(want.tag));
        a_prf_data: assert property (@(posedge clock) disable iff (reset_i)
            prf_wr[s].en |-> prf_wr[s].data == want.value)
            else report_mismatch($sformatf("prf_wr_o[%0d].data", s),
                                 $sampled(prf_wr[s].data), $sampled(want.value));
        a_cdb_valid: assert property (@(posedge clock) disable iff (reset_i)
            cdb[s].valid == (rob_wb[s].valid && want_wr))
            else report_mismatch($sformatf("cdb_o[%0d].valid", s), $sampled(cdb[s].valid),
                                 $sampled(rob_wb[s].valid && want_wr));
        a_cdb_tag: assert property (@(posedge clock) disable iff (reset_i)
            cdb[s].valid |-> cdb[s].phys_tag == want.tag)
            else report_mismatch($sformatf("cdb_o[%0d].phys_tag", s),
                                 $sampled(cdb[s].phys_tag), $sampled(want.tag));
        a_cdb_value: assert property (@(posedge clock) disable iff (reset_i)
            cdb[s].valid |-> cdb[s].value == want.value)
            else report_mismatch($sformatf("cdb_o[%0d].value", s),
                                 $sampled(cdb[s].value), $sampled(want.value));

        for (genvar b = s + 1; b < wb_cfg_pkg::WB_SLOTS; b++) begin : g_pair
            a_rob_distinct: assert property (@(posedge clock) disable iff (reset_i)
                (rob_wb[s].valid && rob_wb[b].valid) |-> rob_wb[s].rob_idx != rob_wb[b].rob_idx)
                else end_with_failure("one ROB index completed on two slots in the same cycle");
        end
    end

    for (genvar p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin : g_prod
        a_credit_range: assert property (@(posedge clock) disable iff (reset_i)
            credits[p] >= 0 && credits[p] <= wb_cfg_pkg::RQ_DEPTH)
            else end_with_failure($sformatf("[FAIL] t=%0t credits[%0d] got %0d expected 0..%0d",
                                            $time, p, $sampled(credits[p]), wb_cfg_pkg::RQ_DEPTH));
        // a queued head is granted within 3 cycles, its credit shows up one later
        a_grant_gap: assert property (@(posedge clock) disable iff (reset_i)
            credit[p] || wait_cnt[p] <= 3)
            else end_with_failure($sformatf("producer %0d went %0d cycles without a grant",
                                            p, $sampled(wait_cnt[p])));
    end

    initial begin
        int cyc;
        bit drained;
        clock    = 1'b0;
        reset_i  = 1'b1;
        fu_res   = '0;
        load_res = '0;
        for (int i = 0; i < wb_cfg_pkg::ROB_DEPTH; i++) begin
            exp_q[i] = '0;
        end
        for (int p = 0; p < wb_cfg_pkg::NUM_PROD; p++) begin
            credits[p] = wb_cfg_pkg::RQ_DEPTH;
        end
        repeat (8) @(posedge clock);
        #1 reset_i = 1'b0;

        for (cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clock);
            #1;
            collect_credits();
            drive_cycle(cyc >= STIM_CYCLES / 2); // second half sends on every credit
        end

        cyc     = 0;
        drained = 1'b0;
        while (!drained && cyc < DRAIN_LIMIT) begin
            @(posedge clock);
            #1;
            fu_res   = '0;
            load_res = '0;
            collect_credits();
            drained = all_returned();
            cyc++;
        end

        if (drained) begin
            $display("** PASS **");
            $finish;
        end else begin
            end_with_failure($sformatf("results still outstanding after %0d drain cycles",
                                       DRAIN_LIMIT));
        end
    end

endmodule

//--- compile.f
hw/wb_cfg_pkg.sv
hw/wb_types_pkg.sv
hw/load_align.sv
hw/result_queue.sv
hw/cdb_arbiter.sv
hw/complete_stage.sv
hw/wb_top.sv
dv/tb_wb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build the writeback testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_wb_top -f compile.f || exit 1

sim_out="$(./obj_dir/Vtb_wb_top 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qxF '** PASS **' && echo "simulation passed" || { echo "simulation failed"; exit 1; }
